/* test/iconnect_vectors.txt */
# op(0 rd 1 wr 2 counter rd) addr width(0 b 1 h 2 w) wdata target(0 bridge 1 aes 2 timer)
# resp(1 ok 2 err) rdata flush irq, all hex
0 00001000 2 00000000 0 1 FFFFEFFF 0 1
1 20000040 2 DEADBEEF 0 1 DFFFFFBF 0 1
0 0C47FFFC 2 00000000 0 1 F3B80003 0 1
0 0C490000 2 00000000 0 1 F3B6FFFF 0 1
1 0C480024 2 A5A50001 1 1 00000024 0 1
0 0C48FF80 2 00000000 1 1 00000000 0 1
1 0C480110 2 00000100 2 1 00000000 0 0
1 0C480108 2 00000080 2 1 00000000 0 0
1 0C48010C 2 00000001 2 1 00000000 0 1
1 0C480114 2 00000002 2 1 00000000 0 0
0 0C480108 2 00000000 2 1 00000080 0 0
0 0C480114 2 00000000 2 1 00000002 0 0
1 0C480104 2 00000007 2 1 00000000 0 0
0 0C480104 2 00000000 2 1 00000007 0 0
1 0C480118 2 00000005 2 1 00000000 1 0
0 0C480118 2 00000000 2 1 00000005 1 0
0 0C480108 1 00000000 2 2 00000000 1 0
1 0C48011C 2 FFFFFFFF 2 2 00000000 1 0
1 0C480118 2 00000004 2 1 00000000 0 0
1 0C480114 2 00000001 2 1 00000000 0 0
1 0C480110 2 00000080 2 1 00000000 0 1
1 0C480114 2 FFFFFFFF 2 1 00000000 0 0
1 0C480104 2 00000000 2 1 00000000 0 0
1 0C480100 2 00000001 2 1 00000000 0 0
2 0C480108 2 00000000 2 1 00000000 0 0
0 00002000 2 00000000 0 1 FFFFDFFF 0 0
2 0C480108 2 00000000 2 1 00000000 0 0

/* list.f */
+incdir+design
design/ycr_memif_pkg.sv
design/ycr_map_pkg.sv
design/ycr_dmem_router.sv
design/ycr_timer.sv
design/ycr_iconnect.sv
test/ycr_iconnect_tb.sv

/* Bender.yml */
package:
  name: ycr_iconnect

export_include_dirs:
  - design

sources:
  - files:
      - design/ycr_memif_pkg.sv
      - design/ycr_map_pkg.sv
      - design/ycr_dmem_router.sv
      - design/ycr_timer.sv
      - design/ycr_iconnect.sv
  - target: test
    files:
      - test/ycr_iconnect_tb.sv

/* test/ycr_iconnect_tb.sv */
`timescale 1ns/1ps
`include "iconnect_settings.svh"

module ycr_iconnect_tb
   import ycr_memif_pkg::*;
();

localparam int CLK_PERIOD   = 20;
localparam int RESET_CYCLES = 5;
localparam int MAX_VEC      = 64;
localparam int TGT_BRIDGE   = 0;                 // Target codes of the vector file
localparam int TGT_AES      = 1;
localparam int OP_READ      = 0;
localparam int OP_WRITE     = 1;                 // 2 reads the counter, checks growth

logic                           core_clk;
logic                           reset_i;
logic                           core0_dmem_req_i;
mem_cmd_e                       core0_dmem_cmd_i;
mem_width_e                     core0_dmem_width_i;
logic [`YCR_DMEM_AWIDTH-1:0]    core0_dmem_addr_i;
logic [`YCR_DMEM_DWIDTH-1:0]    core0_dmem_wdata_i;
logic                           core0_dmem_req_ack_o;
logic [`YCR_DMEM_DWIDTH-1:0]    core0_dmem_rdata_o;
mem_resp_e                      core0_dmem_resp_o;
logic                           core_dmem_req_o;
mem_cmd_e                       core_dmem_cmd_o;
mem_width_e                     core_dmem_width_o;
logic [`YCR_DMEM_AWIDTH-1:0]    core_dmem_addr_o;
logic [`YCR_DMEM_DWIDTH-1:0]    core_dmem_wdata_o;
logic                           core_dmem_req_ack_i;
logic [`YCR_DMEM_DWIDTH-1:0]    core_dmem_rdata_i;
mem_resp_e                      core_dmem_resp_i;
logic                           aes_dmem_req_o;
mem_cmd_e                       aes_dmem_cmd_o;
mem_width_e                     aes_dmem_width_o;
logic [`YCR_AES_AWIDTH-1:0]     aes_dmem_addr_o;
logic [`YCR_DMEM_DWIDTH-1:0]    aes_dmem_wdata_o;
logic                           aes_dmem_req_ack_i;
logic [`YCR_DMEM_DWIDTH-1:0]    aes_dmem_rdata_i;
mem_resp_e                      aes_dmem_resp_i;
logic [`YCR_TIMER_WIDTH-1:0]    core0_timer_val_o;
logic                           core0_timer_irq_o;
logic                           cfg_dcache_force_flush_o;

// Vector table, one entry per access
logic [31:0] v_op[MAX_VEC], v_addr[MAX_VEC], v_width[MAX_VEC], v_wdata[MAX_VEC];
logic [31:0] v_tgt[MAX_VEC], v_resp[MAX_VEC], v_rdata[MAX_VEC];
logic [31:0] v_flush[MAX_VEC], v_irq[MAX_VEC];
int          vec_cnt;
logic        vectors_loaded;

int unsigned hold_tab[MAX_VEC];                  // Ack delays, drawn once from the seed
int          chk_cnt, err_cnt, fail_cnt;
logic [63:0] prev_val;                           // Last counter sample
logic [31:0] prev_rdata;
logic        have_prev;

ycr_iconnect ycr_iconnect_i (.*);                // Port names match one to one

initial begin
   core_clk = 1'b0;
   forever #(CLK_PERIOD / 2) core_clk = ~core_clk;
end

// ----------------------------------------------------------------------
// Bridge model, answers with the inverted address
// ----------------------------------------------------------------------
initial begin : bridge_model
   logic [`YCR_DMEM_AWIDTH-1:0] addr_q;
   int                          n;
   n                   = 0;
   core_dmem_req_ack_i = 1'b0;
   core_dmem_rdata_i   = '0;
   core_dmem_resp_i    = YCR_MEM_RESP_NOTRDY;
   forever begin
      @(posedge core_clk);
      if (!reset_i && core_dmem_req_o) begin     // Sampled on the edge, stable
         addr_q = core_dmem_addr_o;
         #2;
         core_dmem_resp_i = YCR_MEM_RESP_NOTRDY;
         repeat (hold_tab[n % MAX_VEC]) begin    // Back-pressure
            @(posedge core_clk);
            #2;
         end
         n++;
         core_dmem_req_ack_i = 1'b1;
         @(posedge core_clk);                    // Acceptance
         #2;
         core_dmem_req_ack_i = 1'b0;
         core_dmem_rdata_i   = ~addr_q;
         core_dmem_resp_i    = YCR_MEM_RESP_RDY_OK;
      end else begin
         #2;
         core_dmem_resp_i = YCR_MEM_RESP_NOTRDY;
      end
   end
end

// ----------------------------------------------------------------------
// AES model, answers with its 7-bit address
// ----------------------------------------------------------------------
initial begin : aes_model
   logic [`YCR_AES_AWIDTH-1:0] addr_q;
   int                         n;
   n                  = MAX_VEC / 2;             // Other half of the delay table
   aes_dmem_req_ack_i = 1'b0;
   aes_dmem_rdata_i   = '0;
   aes_dmem_resp_i    = YCR_MEM_RESP_NOTRDY;
   forever begin
      @(posedge core_clk);
      if (!reset_i && aes_dmem_req_o) begin
         addr_q = aes_dmem_addr_o;
         #2;
         aes_dmem_resp_i = YCR_MEM_RESP_NOTRDY;
         repeat (hold_tab[n % MAX_VEC]) begin
            @(posedge core_clk);
            #2;
         end
         n++;
         aes_dmem_req_ack_i = 1'b1;
         @(posedge core_clk);
         #2;
         aes_dmem_req_ack_i = 1'b0;
         aes_dmem_rdata_i   = {{(`YCR_DMEM_DWIDTH-`YCR_AES_AWIDTH){1'b0}}, addr_q};
         aes_dmem_resp_i    = YCR_MEM_RESP_RDY_OK;
      end else begin
         #2;
         aes_dmem_resp_i = YCR_MEM_RESP_NOTRDY;
      end
   end
end

task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
   chk_cnt++;
   if (got !== exp) begin
      err_cnt++;
      $display("ERR %0t ns %s got %0h expected %0h", $time, name, got, exp);
   end
endtask

// ----------------------------------------------------------------------
// One access: hold req until ack, then check the response cycle
// ----------------------------------------------------------------------
task automatic play_vector(input int idx);
   @(posedge core_clk);
   #2;
   core0_dmem_req_i   = 1'b1;
   core0_dmem_cmd_i   = (v_op[idx] == OP_WRITE) ? YCR_MEM_CMD_WR : YCR_MEM_CMD_RD;
   core0_dmem_width_i = mem_width_e'(v_width[idx][1:0]);
   core0_dmem_addr_i  = v_addr[idx];
   core0_dmem_wdata_i = v_wdata[idx];
   @(posedge core_clk);
   while (!core0_dmem_req_ack_o) @(posedge core_clk);
   // Acceptance edge, request still on the ports
   check_value("core_dmem_req_o", core_dmem_req_o, v_tgt[idx] == TGT_BRIDGE);
   check_value("aes_dmem_req_o", aes_dmem_req_o, v_tgt[idx] == TGT_AES);
   if (v_tgt[idx] == TGT_BRIDGE) begin
      check_value("core_dmem_cmd_o", core_dmem_cmd_o, v_op[idx] == OP_WRITE);
      check_value("core_dmem_width_o", core_dmem_width_o, v_width[idx]);
      check_value("core_dmem_addr_o", core_dmem_addr_o, v_addr[idx]);
      check_value("core_dmem_wdata_o", core_dmem_wdata_o, v_wdata[idx]);
   end else if (v_tgt[idx] == TGT_AES) begin
      check_value("aes_dmem_cmd_o", aes_dmem_cmd_o, v_op[idx] == OP_WRITE);
      check_value("aes_dmem_width_o", aes_dmem_width_o, v_width[idx]);
      check_value("aes_dmem_addr_o", aes_dmem_addr_o, v_addr[idx][`YCR_AES_AWIDTH-1:0]);
      check_value("aes_dmem_wdata_o", aes_dmem_wdata_o, v_wdata[idx]);
   end
   #2;
   core0_dmem_req_i = 1'b0;
   @(negedge core_clk);                          // Mid response cycle
   check_value("core0_dmem_resp_o", core0_dmem_resp_o, v_resp[idx]);
   if (v_op[idx] == OP_READ && v_resp[idx] == YCR_MEM_RESP_RDY_OK) begin
      check_value("core0_dmem_rdata_o", core0_dmem_rdata_o, v_rdata[idx]);
   end
   if (v_op[idx] > OP_WRITE) begin
      chk_cnt++;
      if (have_prev && (core0_timer_val_o <= prev_val || core0_dmem_rdata_o <= prev_rdata)) begin
         fail_cnt++;
         $display("Error at %0t ns: the timer did not advance between two reads", $time);
      end
      prev_val   = core0_timer_val_o;
      prev_rdata = core0_dmem_rdata_o;
      have_prev  = 1'b1;
   end
   check_value("cfg_dcache_force_flush_o", cfg_dcache_force_flush_o, v_flush[idx]);
   check_value("core0_timer_irq_o", core0_timer_irq_o, v_irq[idx]);
   @(negedge core_clk);
   check_value("core0_dmem_resp_o", core0_dmem_resp_o, YCR_MEM_RESP_NOTRDY);  // Single beat
endtask

// ----------------------------------------------------------------------
// Main sequence
// ----------------------------------------------------------------------
initial begin : main_seq
   int    fd;
   int    cnt;
   string line;
   vectors_loaded     = 1'b0;
   chk_cnt            = 0;
   err_cnt            = 0;
   fail_cnt           = 0;
   have_prev          = 1'b0;
   vec_cnt            = 0;
   reset_i            = 1'b1;
   core0_dmem_req_i   = 1'b0;
   core0_dmem_cmd_i   = YCR_MEM_CMD_RD;
   core0_dmem_width_i = YCR_MEM_WIDTH_WORD;
   core0_dmem_addr_i  = '0;
   core0_dmem_wdata_i = '0;
   void'($urandom(74));
   foreach (hold_tab[i]) hold_tab[i] = $urandom_range(3, 0);

   fd = $fopen("test/iconnect_vectors.txt", "r");
   if (fd == 0) begin
      fail_cnt++;
      $display("Error: the vector file test/iconnect_vectors.txt could not be opened");
   end else begin
      while (!$feof(fd) && vec_cnt < MAX_VEC) begin
         line = "";
         void'($fgets(line, fd));
         if (line.len() < 2 || line.getc(0) == "#") continue;   // Column notes
         cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h", v_op[vec_cnt], v_addr[vec_cnt],
                       v_width[vec_cnt], v_wdata[vec_cnt], v_tgt[vec_cnt], v_resp[vec_cnt],
                       v_rdata[vec_cnt], v_flush[vec_cnt], v_irq[vec_cnt]);
         if (cnt == 9) vec_cnt++;
      end
      $fclose(fd);
      if (vec_cnt == 0) begin
         fail_cnt++;
         $display("Error: the vector file holds no usable access");
      end
   end
   vectors_loaded = 1'b1;

   repeat (RESET_CYCLES) @(posedge core_clk);
   #2;
   reset_i = 1'b0;
   @(negedge core_clk);
   check_value("core0_timer_irq_o", core0_timer_irq_o, 1'b1);   // Counter equals compare
   check_value("cfg_dcache_force_flush_o", cfg_dcache_force_flush_o, 1'b0);
   check_value("core0_dmem_resp_o", core0_dmem_resp_o, YCR_MEM_RESP_NOTRDY);

   for (int i = 0; i < vec_cnt; i++) begin
      play_vector(i);
   end

   $display("Checks %0d, value errors %0d, other errors %0d", chk_cnt, err_cnt, fail_cnt);
   if (err_cnt == 0 && fail_cnt == 0) begin
      $display(">>> PASS");
   end else begin
      $display(">>> FAIL");
   end
   $finish;
end

// Watchdog, worst case 40 cycles per access
initial begin : watchdog
   int limit;
   wait (vectors_loaded === 1'b1);
   limit = (vec_cnt * 40 + RESET_CYCLES + 10) * CLK_PERIOD;
   #(limit);
   $display("Timeout: the test did not finish within %0d ns, an access was never answered",
            limit);
   $display(">>> FAIL");
   $finish;
end

endmodule : ycr_iconnect_tb

/* design/ycr_iconnect.sv */
`timescale 1ns/1ps
`include "iconnect_settings.svh"

module ycr_iconnect
   import ycr_memif_pkg::*;
(
   input  logic                          core_clk,
   input  logic                          reset_i,

   // Core data port
   input  logic                          core0_dmem_req_i,
   input  mem_cmd_e                      core0_dmem_cmd_i,
   input  mem_width_e                    core0_dmem_width_i,
   input  logic [`YCR_DMEM_AWIDTH-1:0]   core0_dmem_addr_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   core0_dmem_wdata_i,
   output logic                          core0_dmem_req_ack_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   core0_dmem_rdata_o,
   output mem_resp_e                     core0_dmem_resp_o,

   // Bus bridge, everything outside local window
   output logic                          core_dmem_req_o,
   output mem_cmd_e                      core_dmem_cmd_o,
   output mem_width_e                    core_dmem_width_o,
   output logic [`YCR_DMEM_AWIDTH-1:0]   core_dmem_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   core_dmem_wdata_o,
   input  logic                          core_dmem_req_ack_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   core_dmem_rdata_i,
   input  mem_resp_e                     core_dmem_resp_i,

   // AES registers
   output logic                          aes_dmem_req_o,
   output mem_cmd_e                      aes_dmem_cmd_o,
   output mem_width_e                    aes_dmem_width_o,
   output logic [`YCR_AES_AWIDTH-1:0]    aes_dmem_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]   aes_dmem_wdata_o,
   input  logic                          aes_dmem_req_ack_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]   aes_dmem_rdata_i,
   input  mem_resp_e                     aes_dmem_resp_i,

   // Timer and config
   output logic [`YCR_TIMER_WIDTH-1:0]   core0_timer_val_o,
   output logic                          core0_timer_irq_o,
   output logic                          cfg_dcache_force_flush_o
);

// Crossbar to local router
logic                         local_dmem_req,    local_dmem_req_ack;
mem_cmd_e                     local_dmem_cmd;
mem_width_e                   local_dmem_width;
logic [`YCR_DMEM_AWIDTH-1:0]  local_dmem_addr;
logic [`YCR_DMEM_DWIDTH-1:0]  local_dmem_wdata,  local_dmem_rdata;
mem_resp_e                    local_dmem_resp;

// Local router to timer
logic                         timer_dmem_req,    timer_dmem_req_ack;
mem_cmd_e                     timer_dmem_cmd;
mem_width_e                   timer_dmem_width;
logic [`YCR_DMEM_AWIDTH-1:0]  timer_dmem_addr;
logic [`YCR_DMEM_DWIDTH-1:0]  timer_dmem_wdata,  timer_dmem_rdata;
mem_resp_e                    timer_dmem_resp;

logic [`YCR_DMEM_AWIDTH-1:0]  aes_dmem_addr_full;  // Before trim
logic [`YCR_DMEM_DWIDTH-1:0]  riscv_glbl_cfg;

assign aes_dmem_addr_o          = aes_dmem_addr_full[`YCR_AES_AWIDTH-1:0];
assign cfg_dcache_force_flush_o = riscv_glbl_cfg[0];

// ----------------------------------------------------------------------
// First level: bridge vs local window
// ----------------------------------------------------------------------
ycr_dmem_router #(
   .ADDR_MASK      (`YCR_LOCAL_ADDR_MASK    ),
   .ADDR_PATTERN   (`YCR_LOCAL_ADDR_PATTERN )
) u_crossbar (
   .core_clk        (core_clk             ),
   .reset_i         (reset_i              ),
   .dmem_req_i      (core0_dmem_req_i     ),
   .dmem_cmd_i      (core0_dmem_cmd_i     ),
   .dmem_width_i    (core0_dmem_width_i   ),
   .dmem_addr_i     (core0_dmem_addr_i    ),
   .dmem_wdata_i    (core0_dmem_wdata_i   ),
   .dmem_req_ack_o  (core0_dmem_req_ack_o ),
   .dmem_rdata_o    (core0_dmem_rdata_o   ),
   .dmem_resp_o     (core0_dmem_resp_o    ),
   .port0_req_o     (core_dmem_req_o      ),   // Bus bridge
   .port0_cmd_o     (core_dmem_cmd_o      ),
   .port0_width_o   (core_dmem_width_o    ),
   .port0_addr_o    (core_dmem_addr_o     ),
   .port0_wdata_o   (core_dmem_wdata_o    ),
   .port0_req_ack_i (core_dmem_req_ack_i  ),
   .port0_rdata_i   (core_dmem_rdata_i    ),
   .port0_resp_i    (core_dmem_resp_i     ),
   .port1_req_o     (local_dmem_req       ),   // Local window
   .port1_cmd_o     (local_dmem_cmd       ),
   .port1_width_o   (local_dmem_width     ),
   .port1_addr_o    (local_dmem_addr      ),
   .port1_wdata_o   (local_dmem_wdata     ),
   .port1_req_ack_i (local_dmem_req_ack   ),
   .port1_rdata_i   (local_dmem_rdata     ),
   .port1_resp_i    (local_dmem_resp      )
);

// ----------------------------------------------------------------------
// Second level: AES vs timer
// ----------------------------------------------------------------------
ycr_dmem_router #(
   .ADDR_MASK      (`YCR_TIMER_ADDR_MASK    ),
   .ADDR_PATTERN   (`YCR_TIMER_ADDR_PATTERN )
) u_local_router (
   .core_clk        (core_clk             ),
   .reset_i         (reset_i              ),
   .dmem_req_i      (local_dmem_req       ),
   .dmem_cmd_i      (local_dmem_cmd       ),
   .dmem_width_i    (local_dmem_width     ),
   .dmem_addr_i     (local_dmem_addr      ),
   .dmem_wdata_i    (local_dmem_wdata     ),
   .dmem_req_ack_o  (local_dmem_req_ack   ),
   .dmem_rdata_o    (local_dmem_rdata     ),
   .dmem_resp_o     (local_dmem_resp      ),
   .port0_req_o     (aes_dmem_req_o       ),   // AES
   .port0_cmd_o     (aes_dmem_cmd_o       ),
   .port0_width_o   (aes_dmem_width_o     ),
   .port0_addr_o    (aes_dmem_addr_full   ),
   .port0_wdata_o   (aes_dmem_wdata_o     ),
   .port0_req_ack_i (aes_dmem_req_ack_i   ),
   .port0_rdata_i   (aes_dmem_rdata_i     ),
   .port0_resp_i    (aes_dmem_resp_i      ),
   .port1_req_o     (timer_dmem_req       ),   // Timer
   .port1_cmd_o     (timer_dmem_cmd       ),
   .port1_width_o   (timer_dmem_width     ),
   .port1_addr_o    (timer_dmem_addr      ),
   .port1_wdata_o   (timer_dmem_wdata     ),
   .port1_req_ack_i (timer_dmem_req_ack   ),
   .port1_rdata_i   (timer_dmem_rdata     ),
   .port1_resp_i    (timer_dmem_resp      )
);

// ----------------------------------------------------------------------
// Machine timer
// ----------------------------------------------------------------------
ycr_timer i_timer (
   .core_clk        (core_clk             ),
   .reset_i         (reset_i              ),
   .dmem_req_i      (timer_dmem_req       ),
   .dmem_cmd_i      (timer_dmem_cmd       ),
   .dmem_width_i    (timer_dmem_width     ),
   .dmem_addr_i     (timer_dmem_addr      ),
   .dmem_wdata_i    (timer_dmem_wdata     ),
   .dmem_req_ack_o  (timer_dmem_req_ack   ),
   .dmem_rdata_o    (timer_dmem_rdata     ),
   .dmem_resp_o     (timer_dmem_resp      ),
   .timer_val_o     (core0_timer_val_o    ),
   .timer_irq_o     (core0_timer_irq_o    ),
   .glbl_cfg_o      (riscv_glbl_cfg       )
);

endmodule : ycr_iconnect

/* design/ycr_timer.sv */
`timescale 1ns/1ps
`include "iconnect_settings.svh"

module ycr_timer
   import ycr_memif_pkg::*;
   import ycr_map_pkg::*;
(
   input  logic                           core_clk,
   input  logic                           reset_i,

   // Register access
   input  logic                           dmem_req_i,
   input  mem_cmd_e                       dmem_cmd_i,
   input  mem_width_e                     dmem_width_i,
   input  logic [`YCR_DMEM_AWIDTH-1:0]    dmem_addr_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]    dmem_wdata_i,
   output logic                           dmem_req_ack_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]    dmem_rdata_o,
   output mem_resp_e                      dmem_resp_o,

   // Timer and config outputs
   output logic [`YCR_TIMER_WIDTH-1:0]    timer_val_o,
   output logic                           timer_irq_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]    glbl_cfg_o
);

logic                               ctrl_en;     // Counting enable
logic [`YCR_TIMER_DIV_WIDTH-1:0]    div;         // Clocks per tick minus one
logic [`YCR_TIMER_DIV_WIDTH-1:0]    div_cnt;     // Prescaler state
logic [`YCR_TIMER_WIDTH-1:0]        mtime;
logic [`YCR_TIMER_WIDTH-1:0]        mtimecmp;
logic [`YCR_DMEM_DWIDTH-1:0]        glbl_cfg;
logic                               tick;
logic                               access_ok;
logic                               wr_en;
timer_reg_e                         reg_off;
logic [`YCR_DMEM_DWIDTH-1:0]        rdata_nxt;

// ----------------------------------------------------------------------
// Access decode
// ----------------------------------------------------------------------
assign reg_off   = timer_reg_e'(dmem_addr_i[4:2]);
assign access_ok = (dmem_width_i == YCR_MEM_WIDTH_WORD)
                 & (dmem_addr_i[1:0] == 2'b00)             // Aligned only
                 & (dmem_addr_i[7:5] == 3'b000)            // First 8 words
                 & (dmem_addr_i[4:2] != 3'd7);             // Unused slot
assign wr_en     = dmem_req_i & access_ok & (dmem_cmd_i == YCR_MEM_CMD_WR);

assign dmem_req_ack_o = dmem_req_i;                        // Never stalls

// ----------------------------------------------------------------------
// Prescaler and counter
// ----------------------------------------------------------------------
assign tick = ctrl_en & (div_cnt == div);

always_ff @(posedge core_clk) begin
   if (reset_i) begin
      div_cnt <= '0;
   end else if (!ctrl_en || tick) begin
      div_cnt <= '0;                                       // Restart period
   end else begin
      div_cnt <= div_cnt + 1'b1;
   end
end

always_ff @(posedge core_clk) begin
   if (reset_i) begin
      ctrl_en  <= 1'b0;
      div      <= '0;
      mtime    <= '0;
      mtimecmp <= '0;
      glbl_cfg <= '0;
   end else begin
      if (wr_en) begin
         case (reg_off)
            TMR_CTRL:        ctrl_en         <= dmem_wdata_i[0];
            TMR_DIV:         div             <= dmem_wdata_i;
            TMR_MTIMECMP_LO: mtimecmp[31:0]  <= dmem_wdata_i;
            TMR_MTIMECMP_HI: mtimecmp[63:32] <= dmem_wdata_i;
            TMR_GLBL_CFG:    glbl_cfg        <= dmem_wdata_i;
            default:         ;                             // Counter below
         endcase
      end
      // Written half wins over a tick in the same cycle
      if (wr_en && reg_off == TMR_MTIME_LO) begin
         mtime[31:0] <= dmem_wdata_i;
      end else if (wr_en && reg_off == TMR_MTIME_HI) begin
         mtime[63:32] <= dmem_wdata_i;
      end else if (tick) begin
         mtime <= mtime + 1'b1;
      end
   end
end

// ----------------------------------------------------------------------
// Read path, answered one cycle after ack
// ----------------------------------------------------------------------
always_comb begin
   case (reg_off)
      TMR_CTRL:        rdata_nxt = {{(`YCR_DMEM_DWIDTH-1){1'b0}}, ctrl_en};
      TMR_DIV:         rdata_nxt = div;
      TMR_MTIME_LO:    rdata_nxt = mtime[31:0];
      TMR_MTIME_HI:    rdata_nxt = mtime[63:32];
      TMR_MTIMECMP_LO: rdata_nxt = mtimecmp[31:0];
      TMR_MTIMECMP_HI: rdata_nxt = mtimecmp[63:32];
      TMR_GLBL_CFG:    rdata_nxt = glbl_cfg;
      default:         rdata_nxt = '0;
   endcase
end

always_ff @(posedge core_clk) begin
   if (reset_i) begin
      dmem_resp_o <= YCR_MEM_RESP_NOTRDY;
   end else if (dmem_req_i) begin
      dmem_resp_o <= access_ok ? YCR_MEM_RESP_RDY_OK : YCR_MEM_RESP_RDY_ER;
   end else begin
      dmem_resp_o <= YCR_MEM_RESP_NOTRDY;
   end
end

always_ff @(posedge core_clk) begin
   if (dmem_req_i) dmem_rdata_o <= rdata_nxt;              // Payload only
end

assign timer_val_o = mtime;
assign timer_irq_o = (mtime >= mtimecmp);                  // Level, not pulse
assign glbl_cfg_o  = glbl_cfg;

// One response per accepted request
assert property (@(posedge core_clk) disable iff (reset_i)
   (dmem_resp_o != YCR_MEM_RESP_NOTRDY) |-> $past(dmem_req_i && dmem_req_ack_o));

endmodule : ycr_timer

/* design/ycr_dmem_router.sv */
`timescale 1ns/1ps
`include "iconnect_settings.svh"

module ycr_dmem_router
   import ycr_memif_pkg::*;
   import ycr_map_pkg::*;
#(
   parameter logic [`YCR_DMEM_AWIDTH-1:0] ADDR_MASK    = `YCR_TIMER_ADDR_MASK,
   parameter logic [`YCR_DMEM_AWIDTH-1:0] ADDR_PATTERN = `YCR_TIMER_ADDR_PATTERN
) (
   input  logic                         core_clk,
   input  logic                         reset_i,

   // Initiator side
   input  logic                         dmem_req_i,
   input  mem_cmd_e                     dmem_cmd_i,
   input  mem_width_e                   dmem_width_i,
   input  logic [`YCR_DMEM_AWIDTH-1:0]  dmem_addr_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]  dmem_wdata_i,
   output logic                         dmem_req_ack_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]  dmem_rdata_o,
   output mem_resp_e                    dmem_resp_o,

   // Port 0, default target
   output logic                         port0_req_o,
   output mem_cmd_e                     port0_cmd_o,
   output mem_width_e                   port0_width_o,
   output logic [`YCR_DMEM_AWIDTH-1:0]  port0_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]  port0_wdata_o,
   input  logic                         port0_req_ack_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]  port0_rdata_i,
   input  mem_resp_e                    port0_resp_i,

   // Port 1, matching window
   output logic                         port1_req_o,
   output mem_cmd_e                     port1_cmd_o,
   output mem_width_e                   port1_width_o,
   output logic [`YCR_DMEM_AWIDTH-1:0]  port1_addr_o,
   output logic [`YCR_DMEM_DWIDTH-1:0]  port1_wdata_o,
   input  logic                         port1_req_ack_i,
   input  logic [`YCR_DMEM_DWIDTH-1:0]  port1_rdata_i,
   input  mem_resp_e                    port1_resp_i
);

route_e req_sel;                        // Target of current request
route_e resp_sel;                       // Target owing the next response

// ----------------------------------------------------------------------
// Request path, fully combinational
// ----------------------------------------------------------------------
assign req_sel = ((dmem_addr_i & ADDR_MASK) == ADDR_PATTERN) ? ROUTE_PORT1 : ROUTE_PORT0;

assign port0_req_o   = dmem_req_i & (req_sel == ROUTE_PORT0);
assign port1_req_o   = dmem_req_i & (req_sel == ROUTE_PORT1);

// Fields fan out to both, req qualifies them
assign port0_cmd_o   = dmem_cmd_i;
assign port0_width_o = dmem_width_i;
assign port0_addr_o  = dmem_addr_i;
assign port0_wdata_o = dmem_wdata_i;
assign port1_cmd_o   = dmem_cmd_i;
assign port1_width_o = dmem_width_i;
assign port1_addr_o  = dmem_addr_i;
assign port1_wdata_o = dmem_wdata_i;

assign dmem_req_ack_o = (req_sel == ROUTE_PORT1) ? port1_req_ack_i : port0_req_ack_i;

// ----------------------------------------------------------------------
// Response steering
// ----------------------------------------------------------------------
// Captured on the accepting edge, used for one cycle after
always_ff @(posedge core_clk) begin
   if (reset_i) begin
      resp_sel <= ROUTE_PORT0;
   end else if (dmem_req_i && dmem_req_ack_o) begin
      resp_sel <= req_sel;
   end
end

assign dmem_resp_o  = (resp_sel == ROUTE_PORT1) ? port1_resp_i  : port0_resp_i;
assign dmem_rdata_o = (resp_sel == ROUTE_PORT1) ? port1_rdata_i : port0_rdata_i;

// Exclusive target select
assert property (@(posedge core_clk) disable iff (reset_i)
   !(port0_req_o && port1_req_o));

// Targets must not ack an absent request
assert property (@(posedge core_clk) disable iff (reset_i)
   dmem_req_ack_o |-> dmem_req_i);

endmodule : ycr_dmem_router

/* design/ycr_map_pkg.sv */
package ycr_map_pkg;

   // Router target
   typedef enum logic {
      ROUTE_PORT0 = 1'b0,              // Address outside window
      ROUTE_PORT1 = 1'b1               // Address inside window
   } route_e;

   // Timer word offsets, addr[4:2]
   typedef enum logic [2:0] {
      TMR_CTRL       = 3'd0,           // Bit 0 enables counting
      TMR_DIV        = 3'd1,           // Prescaler
      TMR_MTIME_LO   = 3'd2,
      TMR_MTIME_HI   = 3'd3,
      TMR_MTIMECMP_LO = 3'd4,
      TMR_MTIMECMP_HI = 3'd5,
      TMR_GLBL_CFG   = 3'd6            // Bit 0 forces dcache flush
   } timer_reg_e;

endpackage : ycr_map_pkg

/* design/ycr_memif_pkg.sv */
package ycr_memif_pkg;

   // Access direction
   typedef enum logic {
      YCR_MEM_CMD_RD = 1'b0,
      YCR_MEM_CMD_WR = 1'b1
   } mem_cmd_e;

   // Access size
   typedef enum logic [1:0] {
      YCR_MEM_WIDTH_BYTE  = 2'b00,
      YCR_MEM_WIDTH_HWORD = 2'b01,
      YCR_MEM_WIDTH_WORD  = 2'b10      // Only size the timer takes
   } mem_width_e;

   // Response strobe, idle unless one cycle after acceptance
   typedef enum logic [1:0] {
      YCR_MEM_RESP_NOTRDY = 2'b00,     // Idle
      YCR_MEM_RESP_RDY_OK = 2'b01,     // Data valid
      YCR_MEM_RESP_RDY_ER = 2'b10      // Access refused
   } mem_resp_e;

endpackage : ycr_memif_pkg

/* design/iconnect_settings.svh */
`ifndef ICONNECT_SETTINGS_SVH
`define ICONNECT_SETTINGS_SVH

// ----------------------------------------------------------------------
// Data port widths
// ----------------------------------------------------------------------
`define YCR_DMEM_AWIDTH          32             // Byte address
`define YCR_DMEM_DWIDTH          32             // One word per beat

// ----------------------------------------------------------------------
// Address map
// ----------------------------------------------------------------------
// Local window, 64 KiB
`define YCR_LOCAL_ADDR_MASK      32'hFFFF_0000
`define YCR_LOCAL_ADDR_PATTERN   32'h0C48_0000

// Timer, 256 bytes inside local window
`define YCR_TIMER_ADDR_MASK      32'hFFFF_FF00
`define YCR_TIMER_ADDR_PATTERN   32'h0C48_0100

// Rest of local window belongs to AES
`define YCR_AES_AWIDTH           7              // AES register space

// ----------------------------------------------------------------------
// Timer geometry
// ----------------------------------------------------------------------
`define YCR_TIMER_WIDTH          64             // Counter and compare
`define YCR_TIMER_DIV_WIDTH      32             // Divider register

`endif
